//--- dv/uram_sys_asserts.sv
// UltraRAM subsystem protocol checks
`timescale 1ns/100ps
`default_nettype none

module uram_sys_asserts #(
  parameter int PIPELINES = 3
) (
  input  wire logic                clk,
  input  wire logic                rsta,
  input  wire logic                i_b_en,
  input  wire logic                i_b_we,
  input  wire logic                o_pready,
  input  wire logic                o_pslverr,
  input  wire logic                o_b_valid,
  input  wire logic                o_init_done,
  input  wire uram_pkg::ram_data_t o_prdata,
  input  wire uram_pkg::ram_data_t o_b_rdata
);

  int fail_count = 0;   // Failed assertions so far

  // APB held off during the clear sweep
  a_ready_after_init : assert property (@(posedge clk) disable iff (rsta)
    o_pready |-> o_init_done)
    else
    begin
      $error("o_pready high before o_init_done");
      fail_count++;
    end

  a_err_with_ready : assert property (@(posedge clk) disable iff (rsta)
    o_pslverr |-> o_pready)
    else
    begin
      $error("o_pslverr without o_pready");
      fail_count++;
    end

  // Fixed port B read latency
  a_b_latency : assert property (@(posedge clk) disable iff (rsta)
    (i_b_en && !i_b_we) |-> ##(PIPELINES+2) o_b_valid)
    else
    begin
      $error("o_b_valid missing after port B read");
      fail_count++;
    end

  // Quiet outputs once reset is seen
  a_reset_values : assert property (@(posedge clk)
    rsta |=> (!o_pready && !o_pslverr && !o_b_valid && !o_init_done
              && (o_prdata == '0) && (o_b_rdata == '0)))
    else
    begin
      $error("outputs not at reset values");
      fail_count++;
    end

endmodule

bind uram_sys uram_sys_asserts #(.PIPELINES(PIPELINES)) u_asserts (
  .clk (clk), .rsta (rsta), .i_b_en (i_b_en), .i_b_we (i_b_we),
  .o_pready (o_pready), .o_pslverr (o_pslverr), .o_b_valid (o_b_valid),
  .o_init_done (o_init_done), .o_prdata (o_prdata), .o_b_rdata (o_b_rdata)
);

`default_nettype wire

//--- dv/uram_sys_tb.sv
// UltraRAM subsystem testbench
`timescale 1ns/100ps
`default_nettype none

module uram_sys_tb;
  import uram_pkg::*;

  localparam int PIPELINES = 3;
  localparam int LAT       = PIPELINES + 2;   // Read latency in cycles
  localparam int N_XFER    = 400;             // Upper bound on transfers
  localparam int LIMIT     = 2 * (DEPTH + 1) + N_XFER * (PIPELINES + 4) + 1000;

  logic clk;
  logic rsta;
  logic psel, penable, pwrite;
  apb_addr_t paddr;
  ram_data_t pwdata, prdata, b_rdata, b_wdata;
  logic pready, pslverr, b_en, b_we, b_valid, init_done;
  ram_addr_t b_addr;

  ram_data_t model [DEPTH];    // Reference memory
  int        exp_cyc [$];      // Expected o_b_valid cycle
  ram_data_t exp_dat [$];
  int        cyc;
  int        errors;

  uram_sys #(.PIPELINES(PIPELINES)) DUT (
    .clk (clk), .rsta (rsta),
    .i_psel (psel), .i_penable (penable), .i_pwrite (pwrite),
    .i_paddr (paddr), .i_pwdata (pwdata), .o_prdata (prdata),
    .o_pready (pready), .o_pslverr (pslverr),
    .i_b_en (b_en), .i_b_we (b_we), .i_b_addr (b_addr), .i_b_wdata (b_wdata),
    .o_b_rdata (b_rdata), .o_b_valid (b_valid), .o_init_done (init_done)
  );

  always #20 clk = ~clk;

  // Cycle count and run limit
  always @(posedge clk)
  begin
    cyc <= cyc + 1;
    if (cyc > LIMIT)
    begin
      $display("Timeout: run exceeded %0d cycles", LIMIT);
      $display("Simulation failed");
      $finish;
    end
  end

  // Port B read returns
  always @(posedge clk)
  begin
    #1;
    if (b_valid)
    begin
      if (exp_cyc.size() == 0)
      begin
        $display("o_b_valid with no port B read outstanding at cycle %0d", cyc);
        errors++;
      end
      else
      begin
        if (exp_cyc[0] != cyc)
        begin
          $display("[ERROR] b_latency expected %0d actual %0d", exp_cyc[0], cyc);
          errors++;
        end
        if (exp_dat[0] != b_rdata)
        begin
          $display("[ERROR] b_read expected %h actual %h", exp_dat[0], b_rdata);
          errors++;
        end
        void'(exp_cyc.pop_front());
        void'(exp_dat.pop_front());
      end
    end
  end

  task automatic check_val(input string name, input longint exp, input longint act);
    if (exp != act)
    begin
      $display("[ERROR] %s expected %h actual %h", name, exp, act);
      errors++;
    end
  endtask

  // One APB transfer, starts and ends 2 ns after an edge
  task automatic apb_xfer(input logic wr, input apb_addr_t a, input ram_data_t wd,
                          output ram_data_t rd, output logic err, output int waits);
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = wr;
    paddr   = a;
    pwdata  = wd;
    @(posedge clk);
    #2;
    penable = 1'b1;
    #1;
    waits = 0;
    while (!pready)
    begin
      @(posedge clk);
      #3;
      waits++;
    end
    rd  = prdata;
    err = pslverr;
    @(posedge clk);
    #2;
    psel    = 1'b0;
    penable = 1'b0;
  endtask

  task automatic apb_write_chk(input ram_addr_t w, input ram_data_t d);
    ram_data_t rd;
    logic      err;
    int        waits;
    apb_xfer(1'b1, {1'b0, w, 2'b00}, d, rd, err, waits);
    model[w] = d;
    check_val("apb_write_wait", 0, waits);
    check_val("apb_write_err", 0, err);
  endtask

  task automatic apb_read_chk(input ram_addr_t w);
    ram_data_t rd;
    logic      err;
    int        waits;
    apb_xfer(1'b0, {1'b0, w, 2'b00}, '0, rd, err, waits);
    check_val("apb_read_data", model[w], rd);
    check_val("apb_read_wait", LAT, waits);
    check_val("apb_read_err", 0, err);
  endtask

  // Drive one port B request for one cycle, no deassert
  task automatic b_issue(input logic wr, input ram_addr_t a, input ram_data_t d);
    b_en    = 1'b1;
    b_we    = wr;
    b_addr  = a;
    b_wdata = d;
    if (wr)
      model[a] = d;
    else
    begin
      exp_cyc.push_back(cyc + LAT);
      exp_dat.push_back(model[a]);
    end
    @(posedge clk);
    #2;
  endtask

  task automatic b_drain();
    b_en = 1'b0;
    b_we = 1'b0;
    while (exp_cyc.size() != 0)
    begin
      @(posedge clk);
      #2;
    end
  endtask

  task automatic reset_dut();
    rsta = 1'b1;
    repeat (4)
    begin
      @(posedge clk);
      #2;
    end
    rsta = 1'b0;
    for (int i = 0; i < DEPTH; i++)
      model[i] = '0;
  endtask

  initial
  begin
    ram_data_t rd;
    logic      err;
    int        waits;
    int        n;
    ram_addr_t w;
    apb_addr_t a;
    ram_addr_t wa [40];        // Round-trip write addresses
    clk = 1'b0;
    rsta = 1'b1;
    cyc = 0;
    errors = 0;
    psel = 1'b0;
    penable = 1'b0;
    pwrite = 1'b0;
    paddr = '0;
    pwdata = '0;
    b_en = 1'b0;
    b_we = 1'b0;
    b_addr = '0;
    b_wdata = '0;
    void'($urandom(32'h8d03_032a));

    // APB read during the clear sweep
    reset_dut();
    fork
      begin
        apb_xfer(1'b0, {1'b0, ram_addr_t'($urandom), 2'b00}, '0, rd, err, waits);
        check_val("init_read_data", 0, rd);
        check_val("init_read_err", 0, err);
        check_val("init_read_wait", DEPTH + LAT, waits);   // Access only once cleared
      end
      begin
        n = 0;
        do
        begin
          @(posedge clk);
          #1;
          n++;
        end while (!init_done);
        check_val("init_done_cycles", DEPTH + 1, n);
      end
    join

    // APB round trip
    for (int i = 0; i < 40; i++)
    begin
      wa[i] = ram_addr_t'($urandom);
      apb_write_chk(wa[i], $urandom);
    end
    for (int i = 0; i < 40; i++)
      apb_read_chk(wa[i]);

    // Cross-port data
    for (int i = 0; i < 20; i++)
    begin
      w = ram_addr_t'($urandom);
      apb_write_chk(w, $urandom);
      b_issue(1'b0, w, '0);
      b_drain();
      w = ram_addr_t'($urandom);
      b_issue(1'b1, w, $urandom);
      b_drain();
      apb_read_chk(w);
    end

    // Port B back-to-back with interleaved writes
    for (int i = 0; i < 100; i++)
      b_issue(($urandom % 4) == 0, ram_addr_t'($urandom % 64), $urandom);
    b_drain();

    // Unaligned and out-of-range transfers
    for (int i = 0; i < 16; i++)
    begin
      w = ram_addr_t'($urandom);
      if (i % 2)
        a = {1'b1, w, 2'b00};
      else
        a = {1'b0, w, 2'($urandom % 3 + 1)};
      apb_xfer(i % 4 < 2, a, $urandom, rd, err, waits);
      check_val("bad_err", 1, err);
      check_val("bad_wait", 0, waits);
      check_val("bad_rdata", 0, rd);
      apb_read_chk(w);
    end

    // Second reset clears everything, sampled where data was written
    reset_dut();
    while (!init_done)
    begin
      @(posedge clk);
      #2;
    end
    for (int i = 0; i < 30; i++)
      apb_read_chk(wa[i]);
    for (int i = 0; i < 30; i++)
      b_issue(1'b0, wa[i + 10], '0);
    b_drain();

    repeat (2) @(posedge clk);
    $display("Checks done, check errors: %0d, assertion failures: %0d",
             errors, DUT.u_asserts.fail_count);
    if ((errors == 0) && (DUT.u_asserts.fail_count == 0))
      $display("Simulation completed successfully");
    else
      $display("Simulation failed");
    $finish;
  end

endmodule

`default_nettype wire

//--- flist.f
rtl/uram_pkg.sv
rtl/ram_port_if.sv
rtl/apb_ram_bridge.sv
rtl/uram_clear.sv
rtl/uram_tdp.sv
rtl/uram_sys.sv
dv/uram_sys_asserts.sv
dv/uram_sys_tb.sv

//--- rtl/apb_ram_bridge.sv
// APB slave for memory port A
`timescale 1ns/100ps
`default_nettype none

module apb_ram_bridge (
  input  wire logic                 clk,
  input  wire logic                 rsta,
  input  wire logic                 i_init_done,   // Clear sweep finished

  // APB slave
  input  wire logic                 i_psel,
  input  wire logic                 i_penable,
  input  wire logic                 i_pwrite,
  input  wire uram_pkg::apb_addr_t  i_paddr,       // Byte address
  input  wire uram_pkg::ram_data_t  i_pwdata,
  output uram_pkg::ram_data_t       o_prdata,
  output logic                      o_pready,
  output logic                      o_pslverr,

  // Port A request side
  ram_port_if.requester             o_ram
);
  import uram_pkg::*;

  bridge_state_e     state;
  bridge_state_e     state_nxt;
  logic [ADDR_W:0]   word_idx;      // Word index incl. spare bit
  logic              addr_ok;       // Aligned and below DEPTH
  logic              access;        // Live access cycle after init
  logic              read_done;     // Read tag back from memory

  assign word_idx = i_paddr[ADDR_W+2:2];

  // Decode
  assign addr_ok = (i_paddr[1:0] == 2'b00) && (word_idx < DEPTH);

  // Holds off until the clear sweep is over
  assign access = (state == ACCESS) && i_psel && i_penable && i_init_done;

  assign read_done = (state == READ_WAIT) && o_ram.rvalid;

  // State register
  always_ff @(posedge clk)
  begin
    if (rsta)
      state <= IDLE;
    else
      state <= state_nxt;
  end

  // Next state
  always_comb
  begin
    state_nxt = state;
    case (state)
      IDLE:
      begin
        if (i_psel)                           // Setup phase
          state_nxt = ACCESS;
      end
      ACCESS:
      begin
        if (!i_psel)
          state_nxt = IDLE;                   // Master dropped out
        else if (access)
        begin
          if (addr_ok && !i_pwrite)
            state_nxt = READ_WAIT;            // Wait for the tag
          else
            state_nxt = IDLE;                 // Write or error done now
        end
      end
      READ_WAIT:
      begin
        if (o_ram.rvalid)
          state_nxt = IDLE;
      end
      default:
        state_nxt = IDLE;
    endcase
  end

  // Single port A request per transfer, first access cycle only
  assign o_ram.en    = access && addr_ok;           // Bad address touches nothing
  assign o_ram.we    = i_pwrite;
  assign o_ram.addr  = i_paddr[ADDR_W+1:2];         // Drop byte offset
  assign o_ram.wdata = i_pwdata;

  // Completion
  // Writes and errors finish at once, reads on the returning tag
  assign o_pready  = (access && (i_pwrite || !addr_ok)) || read_done;
  assign o_pslverr = access && !addr_ok;

  // Memory output register holds the word, zero outside read completion
  assign o_prdata = read_done ? o_ram.rdata : '0;

endmodule

`default_nettype wire

//--- rtl/ram_port_if.sv
// Memory port request and response
`timescale 1ns/100ps
`default_nettype none

interface ram_port_if;
  import uram_pkg::*;

  // Request, one cycle per access
  logic      en;       // Request strobe
  logic      we;       // 1 write, 0 read
  ram_addr_t addr;     // Word address
  ram_data_t wdata;    // Write data

  // Response
  ram_data_t rdata;    // Held until next rvalid
  logic      rvalid;   // One-cycle read tag

  // Side that issues requests
  modport requester (
    output en, we, addr, wdata,
    input  rdata, rvalid
  );

  // Side that serves them
  modport memory (
    input  en, we, addr, wdata,
    output rdata, rvalid
  );

endinterface

`default_nettype wire

//--- rtl/uram_clear.sv
// Post-reset memory clear sequencer
`timescale 1ns/100ps
`default_nettype none

module uram_clear (
  input  wire logic      clk,
  input  wire logic      rsta,
  ram_port_if.memory     i_req,        // From the bridge
  ram_port_if.requester  o_mem,        // To memory port A
  output logic           o_init_done
);
  import uram_pkg::*;

  clear_state_e  state;
  ram_addr_t     sweep_addr;           // Word being zeroed

  // Sweep from word 0 up, one word per cycle
  always_ff @(posedge clk)
  begin
    if (rsta)
    begin
      state       <= CLEARING;
      sweep_addr  <= '0;
      o_init_done <= 1'b0;
    end
    else
    begin
      o_init_done <= (state == READY);             // One cycle behind the FSM
      if (state == CLEARING)
      begin
        sweep_addr <= sweep_addr + 1'b1;
        if (sweep_addr == ram_addr_t'(DEPTH - 1))  // Last word written
          state <= READY;
      end
    end
  end

  // Port A mux
  always_comb
  begin
    if (state == CLEARING)
    begin
      o_mem.en    = 1'b1;
      o_mem.we    = 1'b1;
      o_mem.addr  = sweep_addr;
      o_mem.wdata = '0;
    end
    else
    begin
      o_mem.en    = i_req.en;          // Straight through
      o_mem.we    = i_req.we;
      o_mem.addr  = i_req.addr;
      o_mem.wdata = i_req.wdata;
    end
  end

  // Response path is never muxed
  assign i_req.rdata  = o_mem.rdata;
  assign i_req.rvalid = o_mem.rvalid;  // Sweep writes make no tag

endmodule

`default_nettype wire

//--- rtl/uram_pkg.sv
// UltraRAM subsystem shared types
`default_nettype none

package uram_pkg;

  localparam int ADDR_W = 10;            // Word address bits
  localparam int DATA_W = 32;            // Same as APB data bus
  localparam int DEPTH  = 1 << ADDR_W;   // 1024 words

  typedef logic [ADDR_W-1:0] ram_addr_t;   // Word address
  typedef logic [DATA_W-1:0] ram_data_t;   // One memory word

  // Byte address with one spare bit, so out-of-range words can be named
  typedef logic [ADDR_W+2:0] apb_addr_t;

  // APB bridge FSM
  typedef enum logic [1:0] {
    IDLE,        // No transfer, or setup phase seen
    ACCESS,      // Access phase, waiting on init or acting
    READ_WAIT    // Port A read in flight
  } bridge_state_e;

  // Clear sequencer FSM
  typedef enum logic {
    CLEARING,    // Zero sweep owns port A
    READY        // Pass-through
  } clear_state_e;

endpackage

`default_nettype wire

//--- rtl/uram_sys.sv
// UltraRAM subsystem top level
`timescale 1ns/100ps
`default_nettype none

module uram_sys #(
  parameter int PIPELINES = 3                    // Read stages per port
) (
  input  wire logic                 clk,
  input  wire logic                 rsta,

  // APB slave, port A
  input  wire logic                 i_psel,
  input  wire logic                 i_penable,
  input  wire logic                 i_pwrite,
  input  wire uram_pkg::apb_addr_t  i_paddr,
  input  wire uram_pkg::ram_data_t  i_pwdata,
  output uram_pkg::ram_data_t       o_prdata,
  output logic                      o_pready,
  output logic                      o_pslverr,

  // Raw port B
  input  wire logic                 i_b_en,
  input  wire logic                 i_b_we,
  input  wire uram_pkg::ram_addr_t  i_b_addr,
  input  wire uram_pkg::ram_data_t  i_b_wdata,
  output uram_pkg::ram_data_t       o_b_rdata,
  output logic                      o_b_valid,

  output logic                      o_init_done    // Memory cleared
);

  ram_port_if if_a_req ();   // Bridge to clear sequencer
  ram_port_if if_a_mem ();   // Clear sequencer to memory
  ram_port_if if_b ();       // Port B pins to memory

  // Port B pins onto its interface
  assign if_b.en     = i_b_en;
  assign if_b.we     = i_b_we;
  assign if_b.addr   = i_b_addr;
  assign if_b.wdata  = i_b_wdata;
  assign o_b_rdata   = if_b.rdata;
  assign o_b_valid   = if_b.rvalid;

  apb_ram_bridge u_bridge (
    .clk         (clk),
    .rsta        (rsta),
    .i_init_done (o_init_done),
    .i_psel      (i_psel),
    .i_penable   (i_penable),
    .i_pwrite    (i_pwrite),
    .i_paddr     (i_paddr),
    .i_pwdata    (i_pwdata),
    .o_prdata    (o_prdata),
    .o_pready    (o_pready),
    .o_pslverr   (o_pslverr),
    .o_ram       (if_a_req)
  );

  uram_clear u_clear (
    .clk         (clk),
    .rsta        (rsta),
    .i_req       (if_a_req),
    .o_mem       (if_a_mem),
    .o_init_done (o_init_done)
  );

  uram_tdp #(
    .PIPELINES (PIPELINES)
  ) u_ram (
    .clk  (clk),
    .rsta (rsta),
    .i_a  (if_a_mem),
    .i_b  (if_b)
  );

endmodule

`default_nettype wire

//--- rtl/uram_tdp.sv
// Pipelined true dual-port UltraRAM
`timescale 1ns/100ps
`default_nettype none

module uram_tdp #(
  parameter int PIPELINES = 3          // Data stages after the array read
) (
  input  wire logic   clk,
  input  wire logic   rsta,
  ram_port_if.memory  i_a,
  ram_port_if.memory  i_b
);
  import uram_pkg::*;

  localparam int NPORTS = 2;

  // Ports gathered into arrays, index 0 is A
  logic [NPORTS-1:0]  en;
  logic [NPORTS-1:0]  we;
  ram_addr_t          addr  [NPORTS];
  ram_data_t          wdata [NPORTS];

  ram_data_t          mem   [DEPTH];   // Shared array, no reset
  ram_data_t          mem_q [NPORTS];  // Array read latch per port

  assign en       = {i_b.en, i_a.en};
  assign we       = {i_b.we, i_a.we};
  assign addr[0]  = i_a.addr;
  assign addr[1]  = i_b.addr;
  assign wdata[0] = i_a.wdata;
  assign wdata[1] = i_b.wdata;

  // Array access
  // No change on write, read latch keeps its old word
  always_ff @(posedge clk)
  begin
    for (int p = 0; p < NPORTS; p++)
    begin
      if (en[p])
      begin
        if (we[p])
          mem[addr[p]] <= wdata[p];
        else
          mem_q[p] <= mem[addr[p]];
      end
    end
  end

  for (genvar p = 0; p < NPORTS; p++)
  begin : g_port
    logic [PIPELINES-1:0]  en_pipe;               // Stage load enables
    logic [PIPELINES:0]    rd_pipe;               // Read tags, one longer
    ram_data_t             data_pipe [PIPELINES];
    ram_data_t             rdata_q;               // Output register
    logic                  rvalid_q;

    // Enable and tag pipelines
    always_ff @(posedge clk)
    begin
      if (rsta)
      begin
        en_pipe <= '0;
        rd_pipe <= '0;
      end
      else
      begin
        en_pipe[0] <= en[p];                      // Lines up with mem_q
        for (int i = 1; i < PIPELINES; i++)
          en_pipe[i] <= en_pipe[i-1];
        rd_pipe <= {rd_pipe[PIPELINES-1:0], en[p] & ~we[p]};
      end
    end

    // Data moves only with its enable token
    always_ff @(posedge clk)
    begin
      if (en_pipe[0])
        data_pipe[0] <= mem_q[p];
      for (int i = 1; i < PIPELINES; i++)
      begin
        if (en_pipe[i])
          data_pipe[i] <= data_pipe[i-1];
      end
    end

    // Output register, loads on reads only
    always_ff @(posedge clk)
    begin
      if (rsta)
      begin
        rdata_q  <= '0;
        rvalid_q <= 1'b0;
      end
      else
      begin
        rvalid_q <= rd_pipe[PIPELINES];           // PIPELINES+2 after request
        if (rd_pipe[PIPELINES])
          rdata_q <= data_pipe[PIPELINES-1];
      end
    end
  end

  // Responses back onto the ports
  assign i_a.rdata  = g_port[0].rdata_q;
  assign i_a.rvalid = g_port[0].rvalid_q;
  assign i_b.rdata  = g_port[1].rdata_q;
  assign i_b.rvalid = g_port[1].rvalid_q;

endmodule

`default_nettype wire
